//--- common/csi_rx_pkg.sv
// CSI-2 formats are fixed here; the header check byte is a plain XOR and not the real ECC
`default_nettype none

package csi_rx_pkg;

    ////////////////////////////// Widths
    typedef logic [7:0]  byte_t;        // One lane byte
    typedef logic [9:0]  pixel_t;       // One RAW10 pixel
    typedef logic [15:0] word_count_t;  // Payload length in bytes
    typedef logic [5:0]  data_type_t;   // Header data type field
    typedef logic [1:0]  vc_t;          // Virtual channel
    typedef logic [31:0] count_t;       // Status counter, also the AXI data width
    typedef logic [15:0] crc_t;
    typedef logic [4:0]  axi_addr_t;

    ////////////////////////////// Data types
    localparam data_type_t dt_frame_start = 6'h00;
    localparam data_type_t dt_frame_end   = 6'h01;
    localparam data_type_t dt_raw10       = 6'h2B;
    localparam data_type_t dt_short_limit = 6'h10;  // Types below this are short packets

    // CRC-16, polynomial given MSB first, applied LSB first
    localparam crc_t crc_init = 16'hFFFF;
    localparam crc_t crc_poly = 16'h1021;

    ////////////////////////////// Register map
    localparam axi_addr_t reg_ctrl            = 5'h00;  // [0] enable, [2:1] vc select
    localparam axi_addr_t reg_frame_count     = 5'h04;
    localparam axi_addr_t reg_hdr_err_count   = 5'h08;
    localparam axi_addr_t reg_crc_err_count   = 5'h0C;
    localparam axi_addr_t reg_last_word_count = 5'h10;

    // Packet control FSM
    typedef enum logic [2:0] {
        hunt,
        header,
        payload,
        crc_lo,
        crc_hi,
        skip
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- csi_rx/csi_rx_packet_ctrl.sv
// Sync is only looked for in hunt; a long packet with a bad header is still skipped by its count
`default_nettype none
`timescale 1ns/100ps

module csi_rx_packet_ctrl
(
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     enable,
    input  csi_rx_pkg::vc_t          vc_sel,
    input  logic                     byte_sync,
    input  logic                     byte_valid,
    input  csi_rx_pkg::byte_t        byte_data,
    output logic                     frame_valid,
    output logic                     line_valid,
    output logic                     pix_byte_valid,
    output logic                     line_start,
    output csi_rx_pkg::byte_t        pix_byte,
    output logic                     crc_start,
    output logic                     crc_byte_valid,
    output logic                     crc_footer_lo_valid,
    output logic                     crc_footer_hi_valid,
    output csi_rx_pkg::byte_t        crc_byte,
    output logic                     frame_end_pulse,
    output logic                     hdr_err_pulse,
    output csi_rx_pkg::word_count_t  word_count,
    output logic                     word_count_valid
);

csi_rx_pkg::ctrl_state_t  state;
logic [1:0]               hdr_idx;   // Next header byte
logic [16:0]              remain;    // Bytes left in payload or skip
csi_rx_pkg::byte_t        hdr0;      // VC and data type byte
csi_rx_pkg::word_count_t  wc_q;
csi_rx_pkg::data_type_t   hdr_dt;
csi_rx_pkg::vc_t          hdr_vc;
logic                     hdr_done;
logic                     hdr_ok;
logic                     accept;
logic                     is_long;

////////////////////////////// Header decode
assign hdr_dt   = hdr0[5:0];
assign hdr_vc   = hdr0[7:6];
assign hdr_done = byte_valid && (state == csi_rx_pkg::header) && (hdr_idx == 2'd3);
assign hdr_ok   = (byte_data == (hdr0 ^ wc_q[7:0] ^ wc_q[15:8]));  // Stand-in for ECC
assign accept   = hdr_ok && enable && (hdr_vc == vc_sel);
assign is_long  = (hdr_dt >= csi_rx_pkg::dt_short_limit);

// Steering to the datapaths, same cycle as the byte
assign crc_start           = hdr_done && accept && is_long;
assign line_start          = crc_start && (hdr_dt == csi_rx_pkg::dt_raw10);
assign crc_byte_valid      = byte_valid && (state == csi_rx_pkg::payload);
assign pix_byte_valid      = crc_byte_valid && line_valid;  // RAW10 lines only
assign crc_footer_lo_valid = byte_valid && (state == csi_rx_pkg::crc_lo);
assign crc_footer_hi_valid = byte_valid && (state == csi_rx_pkg::crc_hi);
assign crc_byte            = byte_data;
assign pix_byte            = byte_data;
assign word_count          = wc_q;

// Header byte capture
always_ff @(posedge clk)
begin
    if (byte_valid && state == csi_rx_pkg::hunt && byte_sync)
        hdr0 <= byte_data;
    if (byte_valid && state == csi_rx_pkg::header)
    begin
        if (hdr_idx == 2'd1)
            wc_q[7:0] <= byte_data;    // WC LSB first
        if (hdr_idx == 2'd2)
            wc_q[15:8] <= byte_data;
    end
end

////////////////////////////// Control FSM
always_ff @(posedge clk or negedge arst_n)
begin
    if (!arst_n)
    begin
        state            <= csi_rx_pkg::hunt;
        hdr_idx          <= 2'd0;
        remain           <= '0;
        frame_valid      <= 1'b0;
        line_valid       <= 1'b0;
        frame_end_pulse  <= 1'b0;
        hdr_err_pulse    <= 1'b0;
        word_count_valid <= 1'b0;
    end
    else
    begin
        frame_end_pulse  <= 1'b0;
        hdr_err_pulse    <= 1'b0;
        word_count_valid <= 1'b0;
        if (byte_valid)
        begin
            case (state)
                csi_rx_pkg::hunt:
                    if (byte_sync)
                    begin
                        state   <= csi_rx_pkg::header;
                        hdr_idx <= 2'd1;
                    end
                csi_rx_pkg::header:
                    if (hdr_idx != 2'd3)
                        hdr_idx <= hdr_idx + 2'd1;
                    else
                    begin
                        hdr_err_pulse <= !hdr_ok && enable;
                        if (!is_long)
                        begin
                            // Short packet, frame markers only
                            if (accept && hdr_dt == csi_rx_pkg::dt_frame_start)
                                frame_valid <= 1'b1;
                            if (accept && hdr_dt == csi_rx_pkg::dt_frame_end)
                            begin
                                frame_valid     <= 1'b0;
                                frame_end_pulse <= 1'b1;
                            end
                            state <= csi_rx_pkg::hunt;
                        end
                        else if (accept)
                        begin
                            word_count_valid <= 1'b1;
                            line_valid       <= (hdr_dt == csi_rx_pkg::dt_raw10);
                            remain           <= {1'b0, wc_q};
                            state            <= (wc_q == '0) ? csi_rx_pkg::crc_lo
                                                             : csi_rx_pkg::payload;
                        end
                        else
                        begin
                            remain <= {1'b0, wc_q} + 17'd2;  // Payload plus footer
                            state  <= csi_rx_pkg::skip;
                        end
                    end
                csi_rx_pkg::payload:
                begin
                    remain <= remain - 17'd1;
                    if (remain == 17'd1)
                        state <= csi_rx_pkg::crc_lo;
                end
                csi_rx_pkg::crc_lo:
                    state <= csi_rx_pkg::crc_hi;
                csi_rx_pkg::crc_hi:
                begin
                    line_valid <= 1'b0;  // Line ends with the footer
                    state      <= csi_rx_pkg::hunt;
                end
                csi_rx_pkg::skip:
                begin
                    remain <= remain - 17'd1;
                    if (remain == 17'd1)
                        state <= csi_rx_pkg::hunt;
                end
                default:
                    state <= csi_rx_pkg::hunt;
            endcase
        end
    end
end

endmodule

`default_nettype wire

//--- csi_rx/csi_rx_raw10_unpack.sv
// Five bytes make four pixels; a partial group at line end is dropped, no back-pressure
`default_nettype none
`timescale 1ns/100ps

module csi_rx_raw10_unpack
(
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     line_start,
    input  logic                     pix_byte_valid,
    input  csi_rx_pkg::byte_t        pix_byte,
    output logic                     pixel_valid,
    output csi_rx_pkg::pixel_t [0:3] pixels    // Pixel 0 first
);

logic [2:0]         grp_cnt;   // Bytes held in current group
csi_rx_pkg::byte_t  msb [0:3];

////////////////////////////// Group counter
always_ff @(posedge clk or negedge arst_n)
begin
    if (!arst_n)
    begin
        grp_cnt     <= 3'd0;
        pixel_valid <= 1'b0;
    end
    else
    begin
        pixel_valid <= 1'b0;
        if (line_start)
            grp_cnt <= 3'd0;
        else if (pix_byte_valid)
        begin
            if (grp_cnt == 3'd4)
            begin
                grp_cnt     <= 3'd0;
                pixel_valid <= 1'b1;  // One cycle after fifth byte
            end
            else
                grp_cnt <= grp_cnt + 3'd1;
        end
    end
end

// MSB bytes, then the LSB byte completes the group
always_ff @(posedge clk)
begin
    if (pix_byte_valid && grp_cnt != 3'd4)
        msb[grp_cnt[1:0]] <= pix_byte;
    if (pix_byte_valid && grp_cnt == 3'd4)
    begin
        for (int i = 0; i < 4; i++)
        begin
            pixels[i] <= {msb[i], pix_byte[2*i +: 2]};
        end
    end
end

endmodule

`default_nettype wire

//--- csi_rx/csi_rx_payload_crc.sv
// CRC-16 over payload bytes only, seed 0xFFFF, no final XOR, footer sent LSB byte first
`default_nettype none
`timescale 1ns/100ps

module csi_rx_payload_crc
(
    input  logic               clk,
    input  logic               arst_n,
    input  logic               crc_start,
    input  logic               crc_byte_valid,
    input  logic               crc_footer_lo_valid,
    input  logic               crc_footer_hi_valid,
    input  csi_rx_pkg::byte_t  crc_byte,
    output logic               crc_err_pulse
);

csi_rx_pkg::crc_t   crc_q;
csi_rx_pkg::byte_t  footer_lo;

// One byte, bit 0 first, reflected polynomial
function automatic csi_rx_pkg::crc_t crc_next(csi_rx_pkg::crc_t crc, csi_rx_pkg::byte_t d);
    csi_rx_pkg::crc_t poly_r;
    csi_rx_pkg::crc_t c;
    for (int i = 0; i < 16; i++)
    begin
        poly_r[i] = csi_rx_pkg::crc_poly[15-i];
    end
    c = crc;
    for (int i = 0; i < 8; i++)
    begin
        if (c[0] ^ d[i])
            c = (c >> 1) ^ poly_r;
        else
            c = c >> 1;
    end
    return c;
endfunction

always_ff @(posedge clk)
begin
    if (crc_start)
        crc_q <= csi_rx_pkg::crc_init;    // Seed at header
    else if (crc_byte_valid)
        crc_q <= crc_next(crc_q, crc_byte);
    if (crc_footer_lo_valid)
        footer_lo <= crc_byte;
end

////////////////////////////// Compare at second footer byte
always_ff @(posedge clk or negedge arst_n)
begin
    if (!arst_n)
        crc_err_pulse <= 1'b0;
    else
        crc_err_pulse <= crc_footer_hi_valid && ({crc_byte, footer_lo} != crc_q);
end

endmodule

`default_nettype wire

//--- hw/csi_rx_regs.sv
// AXI4-Lite slave, one access at a time, responses always OKAY, only reg_ctrl is writable
`default_nettype none
`timescale 1ns/100ps

module csi_rx_regs
(
    input  logic                     clk,
    input  logic                     arst_n,
    input  csi_rx_pkg::axi_addr_t    awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [31:0]              wdata,
    input  logic                     wvalid,
    output logic                     wready,
    output logic                     bvalid,
    input  logic                     bready,
    input  csi_rx_pkg::axi_addr_t    araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output csi_rx_pkg::count_t       rdata,
    output logic                     rvalid,
    input  logic                     rready,
    input  logic                     frame_end_pulse,
    input  logic                     hdr_err_pulse,
    input  logic                     crc_err_pulse,
    input  csi_rx_pkg::word_count_t  word_count,
    input  logic                     word_count_valid,
    output logic                     enable,
    output csi_rx_pkg::vc_t          vc_sel
);

logic [2:0]               ctrl_q;        // vc_sel, enable
csi_rx_pkg::count_t       frame_count;
csi_rx_pkg::count_t       hdr_err_count;
csi_rx_pkg::count_t       crc_err_count;
csi_rx_pkg::word_count_t  last_wc;
csi_rx_pkg::count_t       rd_mux;
logic                     wr_fire;
logic                     rd_fire;

// Saturating increment
function automatic csi_rx_pkg::count_t sat_inc(csi_rx_pkg::count_t c, logic p);
    return (p && c != '1) ? c + 32'd1 : c;
endfunction

assign enable  = ctrl_q[0];
assign vc_sel  = ctrl_q[2:1];
assign wr_fire = awready && awvalid && wvalid;
assign rd_fire = arready && arvalid;

////////////////////////////// Handshakes and registers
always_ff @(posedge clk or negedge arst_n)
begin
    if (!arst_n)
    begin
        awready       <= 1'b0;
        wready        <= 1'b0;
        bvalid        <= 1'b0;
        arready       <= 1'b0;
        rvalid        <= 1'b0;
        ctrl_q        <= 3'd0;
        frame_count   <= '0;
        hdr_err_count <= '0;
        crc_err_count <= '0;
        last_wc       <= '0;
    end
    else
    begin
        // Address and data taken together, one cycle pulse
        awready <= awvalid && wvalid && !bvalid && !awready;
        wready  <= awvalid && wvalid && !bvalid && !awready;
        if (wr_fire)
            bvalid <= 1'b1;
        else if (bvalid && bready)
            bvalid <= 1'b0;
        if (wr_fire && awaddr == csi_rx_pkg::reg_ctrl)
            ctrl_q <= wdata[2:0];

        arready <= arvalid && !rvalid && !arready;
        if (rd_fire)
            rvalid <= 1'b1;
        else if (rvalid && rready)
            rvalid <= 1'b0;  // rdata held until here

        frame_count   <= sat_inc(frame_count, frame_end_pulse);
        hdr_err_count <= sat_inc(hdr_err_count, hdr_err_pulse);
        crc_err_count <= sat_inc(crc_err_count, crc_err_pulse);
        if (word_count_valid)
            last_wc <= word_count;
    end
end

// Read mux, unused offsets give zero
always_comb
begin
    case (araddr)
        csi_rx_pkg::reg_ctrl:            rd_mux = {29'd0, ctrl_q};
        csi_rx_pkg::reg_frame_count:     rd_mux = frame_count;
        csi_rx_pkg::reg_hdr_err_count:   rd_mux = hdr_err_count;
        csi_rx_pkg::reg_crc_err_count:   rd_mux = crc_err_count;
        csi_rx_pkg::reg_last_word_count: rd_mux = {16'd0, last_wc};
        default:                         rd_mux = '0;
    endcase
end

always_ff @(posedge clk)
begin
    if (rd_fire)
        rdata <= rd_mux;
end

endmodule

`default_nettype wire

//--- hw/csi_rx_top.sv
// Single lane, single clock; pixel outputs have no back-pressure since the PHY cannot stall
`default_nettype none
`timescale 1ns/100ps

module csi_rx_top
(
    input  logic                     clk,
    input  logic                     arst_n,
    // Byte side from D-PHY
    input  logic                     byte_sync,
    input  logic                     byte_valid,
    input  csi_rx_pkg::byte_t        byte_data,
    // AXI4-Lite
    input  csi_rx_pkg::axi_addr_t    awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [31:0]              wdata,
    input  logic                     wvalid,
    output logic                     wready,
    output logic                     bvalid,
    input  logic                     bready,
    input  csi_rx_pkg::axi_addr_t    araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output csi_rx_pkg::count_t       rdata,
    output logic                     rvalid,
    input  logic                     rready,
    // Video out
    output logic                     frame_valid,
    output logic                     line_valid,
    output logic                     pixel_valid,
    output csi_rx_pkg::pixel_t [0:3] pixels
);

logic                     enable;
csi_rx_pkg::vc_t          vc_sel;
logic                     pix_byte_valid;
logic                     line_start;
csi_rx_pkg::byte_t        pix_byte;
logic                     crc_start;
logic                     crc_byte_valid;
logic                     crc_footer_lo_valid;
logic                     crc_footer_hi_valid;
csi_rx_pkg::byte_t        crc_byte;
logic                     frame_end_pulse;
logic                     hdr_err_pulse;
logic                     crc_err_pulse;
csi_rx_pkg::word_count_t  word_count;
logic                     word_count_valid;

////////////////////////////// Packet parsing
csi_rx_packet_ctrl inst_packet_ctrl
(
    .clk                 (clk),
    .arst_n              (arst_n),
    .enable              (enable),
    .vc_sel              (vc_sel),
    .byte_sync           (byte_sync),
    .byte_valid          (byte_valid),
    .byte_data           (byte_data),
    .frame_valid         (frame_valid),
    .line_valid          (line_valid),
    .pix_byte_valid      (pix_byte_valid),
    .line_start          (line_start),
    .pix_byte            (pix_byte),
    .crc_start           (crc_start),
    .crc_byte_valid      (crc_byte_valid),
    .crc_footer_lo_valid (crc_footer_lo_valid),
    .crc_footer_hi_valid (crc_footer_hi_valid),
    .crc_byte            (crc_byte),
    .frame_end_pulse     (frame_end_pulse),
    .hdr_err_pulse       (hdr_err_pulse),
    .word_count          (word_count),
    .word_count_valid    (word_count_valid)
);

csi_rx_raw10_unpack inst_raw10_unpack
(
    .clk            (clk),
    .arst_n         (arst_n),
    .line_start     (line_start),
    .pix_byte_valid (pix_byte_valid),
    .pix_byte       (pix_byte),
    .pixel_valid    (pixel_valid),
    .pixels         (pixels)
);

csi_rx_payload_crc inst_payload_crc
(
    .clk                 (clk),
    .arst_n              (arst_n),
    .crc_start           (crc_start),
    .crc_byte_valid      (crc_byte_valid),
    .crc_footer_lo_valid (crc_footer_lo_valid),
    .crc_footer_hi_valid (crc_footer_hi_valid),
    .crc_byte            (crc_byte),
    .crc_err_pulse       (crc_err_pulse)
);

////////////////////////////// Registers
csi_rx_regs inst_regs
(
    .clk              (clk),
    .arst_n           (arst_n),
    .awaddr           (awaddr),
    .awvalid          (awvalid),
    .awready          (awready),
    .wdata            (wdata),
    .wvalid           (wvalid),
    .wready           (wready),
    .bvalid           (bvalid),
    .bready           (bready),
    .araddr           (araddr),
    .arvalid          (arvalid),
    .arready          (arready),
    .rdata            (rdata),
    .rvalid           (rvalid),
    .rready           (rready),
    .frame_end_pulse  (frame_end_pulse),
    .hdr_err_pulse    (hdr_err_pulse),
    .crc_err_pulse    (crc_err_pulse),
    .word_count       (word_count),
    .word_count_valid (word_count_valid),
    .enable           (enable),
    .vc_sel           (vc_sel)
);

endmodule

`default_nettype wire

//--- testbench/csi_rx_properties.sv
// Bound to csi_rx_top; needs a simulator run with assertions enabled, quiet while in reset
`default_nettype none
`timescale 1ns/100ps

module csi_rx_properties
(
    input  logic                clk,
    input  logic                arst_n,
    input  logic                pixel_valid,
    input  logic                line_valid,
    input  logic                bvalid,
    input  logic                bready,
    input  logic                rvalid,
    input  logic                rready,
    input  csi_rx_pkg::count_t  rdata
);

////////////////////////////// Video
pix_in_line: assert property (@(posedge clk) disable iff (!arst_n)
    pixel_valid |-> line_valid)
    else $error("pixel_valid seen outside line_valid");

////////////////////////////// AXI responses
b_hold: assert property (@(posedge clk) disable iff (!arst_n)
    bvalid && !bready |=> bvalid)             // Response waits for bready
    else $error("bvalid dropped before bready");

r_hold: assert property (@(posedge clk) disable iff (!arst_n)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else $error("rvalid or rdata changed before rready");

endmodule

bind csi_rx_top csi_rx_properties props_i
(
    .clk         (clk),
    .arst_n      (arst_n),
    .pixel_valid (pixel_valid),
    .line_valid  (line_valid),
    .bvalid      (bvalid),
    .bready      (bready),
    .rvalid      (rvalid),
    .rready      (rready),
    .rdata       (rdata)
);

`default_nettype wire

//--- testbench/csi_rx_tb.sv
// Run from the project root so that testbench/csi_rx_golden.txt is found; idle gaps come from an LCG
`default_nettype none
`timescale 1ns/100ps

module csi_rx_tb;

logic                     clk;
logic                     arst_n;
logic                     byte_sync;
logic                     byte_valid;
csi_rx_pkg::byte_t        byte_data;
csi_rx_pkg::axi_addr_t    awaddr;
logic                     awvalid;
logic                     awready;
logic [31:0]              wdata;
logic                     wvalid;
logic                     wready;
logic                     bvalid;
logic                     bready;
csi_rx_pkg::axi_addr_t    araddr;
logic                     arvalid;
logic                     arready;
csi_rx_pkg::count_t       rdata;
logic                     rvalid;
logic                     rready;
logic                     frame_valid;
logic                     line_valid;
logic                     pixel_valid;
csi_rx_pkg::pixel_t [0:3] pixels;

logic [7:0]  cmd_kind [$];      // B byte, E packet end, W write, R read, T test start
logic [31:0] cmd_a [$];
logic [31:0] cmd_b [$];
logic [31:0] cmd_c [$];
string       test_names [$];
logic [39:0] pix_q [$];         // Expected groups, pixel 0 in bits 39:30
logic [31:0] rng_state = 32'ha1b757b2;
int          errors = 0;
int          checks = 0;
int          cycle_count = 0;
int          cycle_limit = 0;   // Zero until the golden file is loaded

csi_rx_top dut_i (.*);

initial
begin
    clk = 1'b0;
    forever #2 clk = ~clk;      // 4 ns period
end

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

task automatic compare_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
        errors++;
        $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
endtask

task automatic push_command(input logic [7:0] k, input logic [31:0] a, input logic [31:0] b,
                            input logic [31:0] c);
    cmd_kind.push_back(k);
    cmd_a.push_back(a);
    cmd_b.push_back(b);
    cmd_c.push_back(c);
endtask

////////////////////////////// Golden file
task automatic load_commands();
    int          fd;
    int          rc;
    int          cnt;
    string       tok;
    string       rest;
    logic [31:0] v [0:3];
    fd = $fopen("testbench/csi_rx_golden.txt", "r");
    if (fd == 0)
    begin
        errors++;
        $display("Could not open testbench/csi_rx_golden.txt");
        return;
    end
    while ($fscanf(fd, "%s", tok) == 1)
    begin
        if (tok[0] == "#")
            rc = $fgets(rest, fd);              // Comment line
        else if (tok == "P")
        begin
            rc = $fscanf(fd, "%d", cnt);
            for (int i = 0; i < cnt; i++)
            begin
                rc = $fscanf(fd, "%h", v[0]);
                push_command("B", v[0], (i == 0) ? 1 : 0, 0);  // Sync on first byte
            end
            push_command("E", 0, 0, 0);
        end
        else if (tok == "W")
        begin
            rc = $fscanf(fd, "%h %h", v[0], v[1]);
            push_command("W", v[0], v[1], 0);
        end
        else if (tok == "R")
        begin
            rc = $fscanf(fd, "%h %h %d", v[0], v[1], v[2]);
            push_command("R", v[0], v[1], v[2]);
        end
        else if (tok == "X")
        begin
            rc = $fscanf(fd, "%h %h %h %h", v[0], v[1], v[2], v[3]);
            pix_q.push_back({v[0][9:0], v[1][9:0], v[2][9:0], v[3][9:0]});
        end
        else if (tok == "T")
        begin
            rc = $fscanf(fd, "%s", rest);
            test_names.push_back(rest);
            push_command("T", 0, 0, 0);
        end
        else
        begin
            errors++;
            $display("Unknown command %s in the golden file", tok);
        end
    end
    $fclose(fd);
endtask

////////////////////////////// Byte and AXI drivers
task automatic send_byte(input logic [7:0] b, input logic sync);
    int idle;
    rng_state = lcg_next(rng_state);
    idle      = int'(rng_state[17:16]) % 3;   // 0 to 2 idle cycles
    repeat (idle)
    begin
        @(posedge clk);
        byte_valid <= 1'b0;
    end
    @(posedge clk);
    byte_valid <= 1'b1;
    byte_sync  <= sync;
    byte_data  <= b;
endtask

task automatic end_packet();
    @(posedge clk);
    byte_valid <= 1'b0;
    byte_sync  <= 1'b0;
    @(negedge clk);
    compare_value("line_valid", 32'(line_valid), 32'd0);  // Low once the last byte is taken
endtask

task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk);
    awaddr  <= addr[4:0];
    wdata   <= data;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    bready  <= 1'b0;
    do
        @(negedge clk);
    while (!awready);
    compare_value("wready", 32'(wready), 32'd1);  // Pulses together with awready
    @(posedge clk);                 // Handshake edge
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    do
        @(negedge clk);
    while (!bvalid);
    @(posedge clk);                 // Response waits one edge without bready
    bready <= 1'b1;
    @(posedge clk);
    bready <= 1'b0;
endtask

task automatic read_reg(input logic [31:0] addr, input logic [31:0] exp, input int hold);
    csi_rx_pkg::count_t first;
    string              name;
    name = $sformatf("rdata at 0x%02h", addr[4:0]);
    @(posedge clk);
    araddr  <= addr[4:0];
    arvalid <= 1'b1;
    rready  <= 1'b0;
    do
        @(negedge clk);
    while (!arready);
    @(posedge clk);
    arvalid <= 1'b0;
    do
        @(negedge clk);
    while (!rvalid);
    first = rdata;
    // Stall the read channel, data must hold
    repeat (hold)
    begin
        @(negedge clk);
        compare_value("rvalid", 32'(rvalid), 32'd1);
        compare_value("rdata", rdata, first);
    end
    compare_value(name, first, exp);
    @(posedge clk);
    rready <= 1'b1;
    @(posedge clk);
    rready <= 1'b0;
endtask

task automatic report_test(input string name, input int first_error);
    if (name != "")
        $display("Test %s finished with %0d mismatches", name, errors - first_error);
endtask

////////////////////////////// Pixel monitor
always @(negedge clk)
begin : pixel_check
    logic [39:0] exp;
    if (arst_n && pixel_valid)
    begin
        if (pix_q.size() == 0)
        begin
            errors++;
            $display("A pixel group arrived when none was expected");
        end
        else
        begin
            exp = pix_q.pop_front();
            for (int i = 0; i < 4; i++)
            begin
                compare_value($sformatf("pixels[%0d]", i), 32'(pixels[i]),
                              32'(exp[39-10*i -: 10]));
            end
            compare_value("frame_valid", 32'(frame_valid), 32'd1);  // Bracketing
            compare_value("line_valid", 32'(line_valid), 32'd1);
        end
    end
end

// Watchdog, limit set once the command count is known
initial
begin
    while (cycle_limit == 0 || cycle_count <= cycle_limit)
    begin
        @(posedge clk);
        cycle_count++;
    end
    $display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
    $display("Done: errors found");
    $finish;
end

////////////////////////////// Main sequence
initial
begin
    logic [7:0]  kind;
    logic [31:0] arg_a;
    logic [31:0] arg_b;
    logic [31:0] arg_c;
    string       current;
    int          first_error;
    arst_n     = 1'b0;
    byte_sync  = 1'b0;
    byte_valid = 1'b0;
    byte_data  = '0;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wvalid     = 1'b0;
    bready     = 1'b0;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    current     = "";
    first_error = 0;
    load_commands();
    cycle_limit = 4 * cmd_kind.size() + 200;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    while (cmd_kind.size() > 0)
    begin
        kind  = cmd_kind.pop_front();
        arg_a = cmd_a.pop_front();
        arg_b = cmd_b.pop_front();
        arg_c = cmd_c.pop_front();
        case (kind)
            "B": send_byte(arg_a[7:0], arg_b[0]);
            "E": end_packet();
            "W": write_reg(arg_a, arg_b);
            "R": read_reg(arg_a, arg_b, int'(arg_c));
            default:
            begin
                report_test(current, first_error);  // Previous test done
                current     = test_names.pop_front();
                first_error = errors;
            end
        endcase
    end
    repeat (10) @(posedge clk);
    if (pix_q.size() != 0)
    begin
        errors++;
        $display("%0d expected pixel groups never arrived", pix_q.size());
    end
    compare_value("frame_valid", 32'(frame_valid), 32'd0);  // Last frame end was accepted
    report_test(current, first_error);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
        $display("Done: no errors");
    else
        $display("Done: errors found");
    $finish;
end

endmodule

`default_nettype wire

//--- testbench/csi_rx_golden.txt
# Commands: T test | P count bytes, sync on first | W addr data | R addr expect rready_hold
# X pix0 pix1 pix2 pix3 is one expected pixel group; all fields hex except count and hold
T disabled
P 4 00 00 00 00
P 16 2B 0A 00 21 FE F6 18 0D 91 09 8D 19 85 09 19 84
P 4 01 00 00 01
R 00 0 0
R 04 0 0
R 08 0 0
R 0C 0 0
R 10 0 0
T raw10_frame
W 00 1
P 4 00 00 00 00
P 16 2B 0A 00 21 FE F6 18 0D 91 09 8D 19 85 09 19 84
X 3F9 3D8 061 036
X 025 236 064 214
P 16 2B 0A 00 21 FE F6 18 0D 91 09 8D 19 85 09 19 84
X 3F9 3D8 061 036
X 025 236 064 214
P 4 01 00 00 01
R 04 1 0
R 10 A 0
R 0C 0 0
T bad_header
P 16 2B 0A 00 22 FE F6 18 0D 91 09 8D 19 85 09 19 84
R 08 1 0
R 04 1 0
T crc_error
P 4 00 00 00 00
P 16 2B 0A 00 21 FE F6 18 0D 91 09 8D 19 85 09 19 85
X 3F9 3D8 061 036
X 025 236 064 214
P 16 2B 0A 00 21 FE F6 18 0D 91 09 8D 19 85 09 19 84
X 3F9 3D8 061 036
X 025 236 064 214
P 4 01 00 00 01
R 0C 1 0
R 04 2 0
T virtual_channel
P 4 40 00 00 40
P 16 6B 0A 00 61 FE F6 18 0D 91 09 8D 19 85 09 19 84
P 4 41 00 00 41
R 04 2 0
W 00 3
P 4 40 00 00 40
P 16 6B 0A 00 61 FE F6 18 0D 91 09 8D 19 85 09 19 84
X 3F9 3D8 061 036
X 025 236 064 214
P 4 41 00 00 41
R 04 3 0
R 08 1 0
R 0C 1 0
T ctrl_readback
R 00 3 6
W 04 FF
R 04 3 0
R 14 0 0
W 00 5
R 00 5 3

//--- sources.f
common/csi_rx_pkg.sv
csi_rx/csi_rx_packet_ctrl.sv
csi_rx/csi_rx_raw10_unpack.sv
csi_rx/csi_rx_payload_crc.sv
hw/csi_rx_regs.sv
hw/csi_rx_top.sv
testbench/csi_rx_properties.sv
testbench/csi_rx_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the CSI-2 receiver testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
    -f sources.f --top-module csi_rx_tb -Mdir obj_dir -o csi_rx_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/csi_rx_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
    echo "Simulation reported failures, see $LOG"
    exit 1
fi
echo "Simulation passed"
exit 0
